//--- base_r_rx.f
+incdir+source
source/base_r_rx_pkg.sv
source/crc_byte_stage.sv
source/block_decoder.sv
source/frame_checker.sv
source/base_r_rx.sv
tb/base_r_rx_assertions.sv
tb/base_r_rx_tb.sv

//--- source/base_r_rx.sv
// 10GBASE-R frame receiver top with block decoder, CRC byte lanes and frame checker
`default_nettype none
`include "base_r_rx_macros.svh"

module base_r_rx
    import base_r_rx_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    reset_crc,
    input  wire baser_word_u             rx_data,
    input  wire logic [`BASER_HDR_W-1:0] rx_hdr,
    input  wire logic                    rx_hdr_valid,
    input  wire logic                    cfg_rx_enable,
    output logic                         rx_valid,
    output rx_beat_t                     rx_beat,
    output logic                         rx_start_packet,
    output rx_stat_t                     rx_stat,
    output logic                         stat_rx_err_bad_block
);

    dec_word_t                      dec_word;
    logic [31:0]                    crc_state;
    // entry 0 is the frame CRC, entry i+1 the value after lane i
    logic [`BASER_KEEP_W:0][31:0]   crc_chain;

    block_decoder i_decoder (
        .clk                   (clk),
        .reset_crc             (reset_crc),
        .rx_data               (rx_data),
        .rx_hdr                (rx_hdr),
        .rx_hdr_valid          (rx_hdr_valid),
        .dec_word              (dec_word),
        .stat_rx_err_bad_block (stat_rx_err_bad_block)
    );

    assign crc_chain[0] = crc_state;

    for (genvar i = 0; i < `BASER_KEEP_W; i++) begin : g_crc_lane
        crc_byte_stage i_stage (
            .crc_in    (crc_chain[i]),
            .data_byte (dec_word.data[8*i +: 8]),
            .lane_en   (dec_word.lane_en[i]),
            .crc_out   (crc_chain[i+1])
        );
    end

    frame_checker i_checker (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .cfg_rx_enable   (cfg_rx_enable),
        .dec_word        (dec_word),
        .crc_out         (crc_chain[`BASER_KEEP_W:1]),
        .crc_state       (crc_state),
        .rx_valid        (rx_valid),
        .rx_beat         (rx_beat),
        .rx_start_packet (rx_start_packet),
        .rx_stat         (rx_stat)
    );

endmodule

`default_nettype wire

//--- source/base_r_rx_macros.svh
// widths, sync headers, 64b/66b block type codes and CRC-32 constants
`ifndef BASE_R_RX_MACROS_SVH
`define BASE_R_RX_MACROS_SVH

`define BASER_DATA_W 32
`define BASER_KEEP_W 4
`define BASER_HDR_W 2
`define BASER_PKT_LEN_W 16

// sync headers, bit 0 first on the line
`define BASER_SYNC_DATA 2'b10
`define BASER_SYNC_CTRL 2'b01

`define BASER_BT_CTRL 8'h1e
`define BASER_BT_START_0 8'h78
`define BASER_BT_TERM_0 8'h87
`define BASER_BT_TERM_1 8'h99
`define BASER_BT_TERM_2 8'haa
`define BASER_BT_TERM_3 8'hb4
`define BASER_BT_TERM_4 8'hcc
`define BASER_BT_TERM_5 8'hd2
`define BASER_BT_TERM_6 8'he1
`define BASER_BT_TERM_7 8'hff

// legal codes that close a frame but never open one here
`define BASER_BT_OS_4 8'h2d
`define BASER_BT_START_4 8'h33
`define BASER_BT_OS_START 8'h66
`define BASER_BT_OS_04 8'h55
`define BASER_BT_OS_0 8'h4b

`define BASER_CRC_POLY 32'hedb88320
// register value once the FCS has gone through, no final inversion
`define BASER_CRC_RESIDUE 32'hdebb20e3

`endif

//--- source/base_r_rx_pkg.sv
// shared types for the half-block union, decoded word, output beat, status and frame states
`default_nettype none
`include "base_r_rx_macros.svh"

package base_r_rx_pkg;

    // one half-block, read as plain bytes or as a control block head
    typedef union packed {
        logic [`BASER_KEEP_W-1:0][7:0] bytes;
        struct packed {
            logic [`BASER_DATA_W-9:0] payload;
            // block type is the first byte on the line
            logic [7:0]               block_type;
        } ctrl;
    } baser_word_u;

    typedef struct packed {
        logic [`BASER_DATA_W-1:0] data;
        logic [`BASER_KEEP_W-1:0] lane_en;
        logic                     start;
        logic                     term;
        logic                     framing_err;
    } dec_word_t;

    typedef struct packed {
        logic [`BASER_DATA_W-1:0] tdata;
        logic [`BASER_KEEP_W-1:0] tkeep;
        logic                     tlast;
        logic                     tuser;
    } rx_beat_t;

    typedef struct packed {
        logic                        pkt_good;
        logic                        pkt_bad;
        logic                        err_bad_fcs;
        logic                        err_framing;
        logic [`BASER_PKT_LEN_W-1:0] pkt_len;
    } rx_stat_t;

    typedef enum logic [1:0] {
        FRAME_IDLE,
        FRAME_PREAMBLE,
        FRAME_PAYLOAD
    } frame_state_e;

endpackage

`default_nettype wire

//--- source/block_decoder.sv
// 64b/66b block decoder with terminate realignment, framing and bad-block flags
`default_nettype none
`include "base_r_rx_macros.svh"

module block_decoder
    import base_r_rx_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    reset_crc,
    input  wire baser_word_u             rx_data,
    input  wire logic [`BASER_HDR_W-1:0] rx_hdr,
    input  wire logic                    rx_hdr_valid,
    output dec_word_t                    dec_word,
    output logic                         stat_rx_err_bad_block
);

    baser_word_u              in_word;
    logic [`BASER_HDR_W-1:0]  in_hdr;
    logic                     in_first;

    // how the second half of the current block is handled
    logic [`BASER_KEEP_W-1:0] hi_lane_en;
    logic [`BASER_KEEP_W-1:0] hi_lane_en_next;
    logic                     hi_shift;
    logic                     hi_shift_next;
    logic                     hi_term;
    logic                     hi_term_next;
    logic                     hi_data;
    logic                     hi_data_next;

    logic                     frame_open;
    logic                     frame_open_next;
    logic                     term_ahead;
    logic                     term_ahead_next;
    dec_word_t                dec_next;
    logic                     bad_next;

    logic                     is_start;
    logic                     is_known;
    logic                     term_any;
    logic                     term_hi;
    logic [1:0]               term_cnt;
    logic [`BASER_KEEP_W-1:0] term_lanes;
    logic                     next_is_term0;

    function automatic logic [`BASER_DATA_W-1:0] byte_mask(input logic [`BASER_KEEP_W-1:0] en);
        logic [`BASER_DATA_W-1:0] mask;
        mask = '0;
        for (int i = 0; i < `BASER_KEEP_W; i++) begin
            mask[8*i +: 8] = {8{en[i]}};
        end
        return mask;
    endfunction

    always_comb begin
        is_start = 1'b0;
        is_known = 1'b1;
        term_any = 1'b1;
        term_hi = 1'b0;
        term_cnt = 2'd0;
        case (in_word.ctrl.block_type)
            `BASER_BT_START_0: begin
                is_start = 1'b1;
                term_any = 1'b0;
            end
            `BASER_BT_TERM_0: term_cnt = 2'd0;
            `BASER_BT_TERM_1: term_cnt = 2'd1;
            `BASER_BT_TERM_2: term_cnt = 2'd2;
            `BASER_BT_TERM_3: term_cnt = 2'd3;
            `BASER_BT_TERM_4: term_hi = 1'b1;
            `BASER_BT_TERM_5: begin
                term_hi = 1'b1;
                term_cnt = 2'd1;
            end
            `BASER_BT_TERM_6: begin
                term_hi = 1'b1;
                term_cnt = 2'd2;
            end
            `BASER_BT_TERM_7: begin
                term_hi = 1'b1;
                term_cnt = 2'd3;
            end
            `BASER_BT_CTRL, `BASER_BT_OS_4, `BASER_BT_START_4,
            `BASER_BT_OS_START, `BASER_BT_OS_04, `BASER_BT_OS_0: term_any = 1'b0;
            default: begin
                is_known = 1'b0;
                term_any = 1'b0;
            end
        endcase
    end

    assign term_lanes = 4'b1111 >> (3'd4 - {1'b0, term_cnt});

    // lookahead for a lane-0 terminate right after a data block
    assign next_is_term0 = rx_hdr_valid && rx_hdr == `BASER_SYNC_CTRL &&
                           rx_data.ctrl.block_type == `BASER_BT_TERM_0;

    always_comb begin
        dec_next = '0;
        dec_next.data = in_word;
        bad_next = 1'b0;
        frame_open_next = frame_open;
        term_ahead_next = 1'b0;
        hi_lane_en_next = hi_lane_en;
        hi_shift_next = hi_shift;
        hi_term_next = hi_term;
        hi_data_next = hi_data;

        if (in_first) begin
            hi_lane_en_next = '0;
            hi_shift_next = 1'b0;
            hi_term_next = 1'b0;
            hi_data_next = 1'b0;
            if (in_hdr == `BASER_SYNC_DATA) begin
                dec_next.lane_en = '1;
                dec_next.framing_err = !frame_open;
                hi_lane_en_next = '1;
                hi_data_next = frame_open;
            end else if (in_hdr == `BASER_SYNC_CTRL && term_any) begin
                frame_open_next = 1'b0;
                if (term_hi) begin
                    // D3 is the first byte of the next half-block
                    dec_next.data = {rx_data.bytes[0], in_word[31:8]};
                    dec_next.lane_en = '1;
                    dec_next.term = frame_open && term_cnt == 2'd0;
                    dec_next.framing_err = !frame_open;
                    hi_lane_en_next = term_lanes;
                    hi_shift_next = 1'b1;
                    hi_term_next = frame_open && term_cnt != 2'd0;
                end else if (term_cnt != 2'd0) begin
                    dec_next.data = byte_mask(term_lanes) & {8'd0, in_word[31:8]};
                    dec_next.lane_en = term_lanes;
                    dec_next.term = frame_open;
                    dec_next.framing_err = !frame_open;
                end else begin
                    // the frame was already closed on the previous data word
                    dec_next.framing_err = !term_ahead;
                end
            end else begin
                dec_next.start = in_hdr == `BASER_SYNC_CTRL && is_start;
                dec_next.framing_err = frame_open;
                frame_open_next = in_hdr == `BASER_SYNC_CTRL && is_start;
                bad_next = in_hdr != `BASER_SYNC_CTRL || !is_known;
            end
        end else begin
            if (hi_shift) begin
                dec_next.data = byte_mask(hi_lane_en) & {8'd0, in_word[31:8]};
            end
            dec_next.lane_en = hi_lane_en;
            dec_next.term = hi_term || (hi_data && next_is_term0);
            if (hi_data && next_is_term0) begin
                frame_open_next = 1'b0;
                term_ahead_next = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        in_word <= rx_data;
        in_hdr <= rx_hdr;
        in_first <= rx_hdr_valid;
        hi_lane_en <= hi_lane_en_next;
        hi_shift <= hi_shift_next;
        hi_term <= hi_term_next;
        hi_data <= hi_data_next;
        frame_open <= frame_open_next;
        term_ahead <= term_ahead_next;
        dec_word <= dec_next;
        stat_rx_err_bad_block <= bad_next;

        if (reset_crc) begin
            in_first <= 1'b0;
            hi_lane_en <= '0;
            hi_shift <= 1'b0;
            hi_term <= 1'b0;
            hi_data <= 1'b0;
            frame_open <= 1'b0;
            term_ahead <= 1'b0;
            dec_word.lane_en <= '0;
            dec_word.start <= 1'b0;
            dec_word.term <= 1'b0;
            dec_word.framing_err <= 1'b0;
            stat_rx_err_bad_block <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/crc_byte_stage.sv
// one byte of the reflected Ethernet CRC-32 update, bypassed when the lane is off
`default_nettype none
`include "base_r_rx_macros.svh"

module crc_byte_stage (
    input  wire logic [31:0] crc_in,
    input  wire logic [7:0]  data_byte,
    input  wire logic        lane_en,
    output logic [31:0]      crc_out
);

    logic [31:0] crc_step;

    // bit-serial form, lsb of the byte first
    always_comb begin
        crc_step = crc_in ^ {24'd0, data_byte};
        for (int i = 0; i < 8; i++) begin
            if (crc_step[0]) begin
                crc_step = (crc_step >> 1) ^ `BASER_CRC_POLY;
            end else begin
                crc_step = crc_step >> 1;
            end
        end
    end

    assign crc_out = lane_en ? crc_step : crc_in;

endmodule

`default_nettype wire

//--- source/frame_checker.sv
// frame FSM with preamble drop, beat and status generation and CRC residue check
`default_nettype none
`include "base_r_rx_macros.svh"

module frame_checker
    import base_r_rx_pkg::*;
(
    input  wire logic                           clk,
    input  wire logic                           reset_crc,
    input  wire logic                           cfg_rx_enable,
    input  wire dec_word_t                      dec_word,
    input  wire logic [`BASER_KEEP_W-1:0][31:0] crc_out,
    output logic [31:0]                         crc_state,
    output logic                                rx_valid,
    output rx_beat_t                            rx_beat,
    output logic                                rx_start_packet,
    output rx_stat_t                            rx_stat
);

    frame_state_e                state;
    frame_state_e                state_next;
    logic [31:0]                 crc_next;
    logic [31:0]                 crc_end;
    logic [2:0]                  lane_cnt;
    logic                        fcs_ok;
    logic [`BASER_PKT_LEN_W-1:0] byte_cnt;
    logic [`BASER_PKT_LEN_W-1:0] byte_cnt_next;
    logic                        valid_next;
    logic                        start_next;
    rx_beat_t                    beat_next;
    rx_stat_t                    stat_next;

    // CRC after the last enabled lane of this word
    always_comb begin
        case (dec_word.lane_en)
            4'b0000: begin
                lane_cnt = 3'd0;
                crc_end = crc_state;
            end
            4'b0001: begin
                lane_cnt = 3'd1;
                crc_end = crc_out[0];
            end
            4'b0011: begin
                lane_cnt = 3'd2;
                crc_end = crc_out[1];
            end
            4'b0111: begin
                lane_cnt = 3'd3;
                crc_end = crc_out[2];
            end
            default: begin
                lane_cnt = 3'd4;
                crc_end = crc_out[3];
            end
        endcase
    end

    assign fcs_ok = crc_end == `BASER_CRC_RESIDUE;

    always_comb begin
        state_next = state;
        crc_next = crc_state;
        byte_cnt_next = byte_cnt;
        valid_next = 1'b0;
        start_next = 1'b0;
        stat_next = '0;
        beat_next.tdata = dec_word.data;
        beat_next.tkeep = dec_word.lane_en;
        beat_next.tlast = 1'b0;
        beat_next.tuser = 1'b0;

        case (state)
            FRAME_IDLE: begin
                crc_next = '1;
                byte_cnt_next = '0;
                if (cfg_rx_enable && dec_word.framing_err) begin
                    stat_next.err_framing = 1'b1;
                end else if (cfg_rx_enable && dec_word.start) begin
                    state_next = FRAME_PREAMBLE;
                end
            end
            FRAME_PREAMBLE: begin
                // rest of the preamble and the SFD, nothing to deliver
                if (dec_word.framing_err) begin
                    stat_next.err_framing = 1'b1;
                    state_next = FRAME_IDLE;
                end else begin
                    start_next = 1'b1;
                    state_next = FRAME_PAYLOAD;
                end
            end
            FRAME_PAYLOAD: begin
                valid_next = |dec_word.lane_en;
                byte_cnt_next = byte_cnt + `BASER_PKT_LEN_W'(lane_cnt);
                crc_next = crc_end;
                if (dec_word.framing_err) begin
                    // abort closes the frame on this word
                    valid_next = 1'b1;
                    beat_next.tkeep = '1;
                    beat_next.tlast = 1'b1;
                    beat_next.tuser = 1'b1;
                    byte_cnt_next = byte_cnt + `BASER_PKT_LEN_W'(`BASER_KEEP_W);
                    stat_next.pkt_bad = 1'b1;
                    stat_next.err_framing = 1'b1;
                    stat_next.pkt_len = byte_cnt_next;
                    crc_next = '1;
                    state_next = FRAME_IDLE;
                end else if (dec_word.term) begin
                    beat_next.tlast = 1'b1;
                    beat_next.tuser = !fcs_ok;
                    stat_next.pkt_good = fcs_ok;
                    stat_next.pkt_bad = !fcs_ok;
                    stat_next.err_bad_fcs = !fcs_ok;
                    stat_next.pkt_len = byte_cnt_next;
                    crc_next = '1;
                    state_next = FRAME_IDLE;
                end
            end
            default: begin
                state_next = FRAME_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        state <= state_next;
        crc_state <= crc_next;
        byte_cnt <= byte_cnt_next;
        rx_valid <= valid_next;
        rx_beat <= beat_next;
        rx_start_packet <= start_next;
        rx_stat <= stat_next;

        if (reset_crc) begin
            state <= FRAME_IDLE;
            crc_state <= '1;
            byte_cnt <= '0;
            rx_valid <= 1'b0;
            rx_start_packet <= 1'b0;
            rx_stat <= '0;
        end
    end

endmodule

`default_nettype wire

//--- tb/base_r_rx_assertions.sv
// concurrent protocol checks on the receiver outputs and their bind to the top level
`default_nettype none

module base_r_rx_assertions
    import base_r_rx_pkg::*;
(
    input wire logic     clk,
    input wire logic     reset_crc,
    input wire logic     rx_valid,
    input wire rx_beat_t rx_beat,
    input wire logic     rx_start_packet,
    input wire rx_stat_t rx_stat
);

    timeunit 1ns;
    timeprecision 1ps;

    // the start strobe leads the first beat by one cycle
    start_apart_from_beat: assert property (
        @(posedge clk) disable iff (reset_crc) !(rx_start_packet && rx_valid)
    ) else $error("rx_start_packet high together with rx_valid");

    good_bad_exclusive: assert property (
        @(posedge clk) disable iff (reset_crc) !(rx_stat.pkt_good && rx_stat.pkt_bad)
    ) else $error("pkt_good and pkt_bad high together");

    status_on_last_beat: assert property (
        @(posedge clk) disable iff (reset_crc)
        (rx_stat.pkt_good || rx_stat.pkt_bad) |-> (rx_valid && rx_beat.tlast)
    ) else $error("end-of-frame status without a tlast beat");

endmodule

bind base_r_rx base_r_rx_assertions i_assertions (
    .clk             (clk),
    .reset_crc       (reset_crc),
    .rx_valid        (rx_valid),
    .rx_beat         (rx_beat),
    .rx_start_packet (rx_start_packet),
    .rx_stat         (rx_stat)
);

`default_nettype wire

//--- tb/base_r_rx_tb.sv
// receiver testbench with clock, LFSR, frame table, block encoder, reference CRC and checks
`default_nettype none
`include "base_r_rx_macros.svh"

module base_r_rx_tb
    import base_r_rx_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS = 13;
    localparam logic [63:0] IDLE_BLOCK = {56'd0, `BASER_BT_CTRL};
    // lane-0 start, six preamble bytes and the SFD
    localparam logic [63:0] START_BLOCK = {8'hd5, {6{8'h55}}, `BASER_BT_START_0};

    typedef enum logic [1:0] {
        OUT_GOOD,
        OUT_BAD_FCS,
        OUT_FRAMING,
        OUT_NONE
    } outcome_e;

    typedef struct packed {
        logic [15:0] pay_len;
        logic [2:0]  term_lane;
        logic        corrupt_fcs;
        logic        abort;
        logic        bad_block;
        logic        enable;
        outcome_e    outcome;
    } row_t;

    logic                    clk;
    logic                    reset_crc;
    baser_word_u             rx_data;
    logic [`BASER_HDR_W-1:0] rx_hdr;
    logic                    rx_hdr_valid;
    logic                    cfg_rx_enable;
    logic                    rx_valid;
    rx_beat_t                rx_beat;
    logic                    rx_start_packet;
    rx_stat_t                rx_stat;
    logic                    stat_rx_err_bad_block;

    row_t        rows [NUM_ROWS];
    rx_beat_t    exp_beats [$];
    rx_stat_t    exp_stats [$];
    logic [15:0] lfsr;
    int          cycle;
    int          cycle_limit;
    int          errors;
    int          checks;
    int          starts_seen;
    int          bad_seen;
    int          start_cycle;
    logic        in_frame;
    logic        first_beat;

    base_r_rx i_dut (
        .clk                   (clk),
        .reset_crc             (reset_crc),
        .rx_data               (rx_data),
        .rx_hdr                (rx_hdr),
        .rx_hdr_valid          (rx_hdr_valid),
        .cfg_rx_enable         (cfg_rx_enable),
        .rx_valid              (rx_valid),
        .rx_beat               (rx_beat),
        .rx_start_packet       (rx_start_packet),
        .rx_stat               (rx_stat),
        .stat_rx_err_bad_block (stat_rx_err_bad_block)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle_limit > 0 && cycle >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[15];
            lfsr = lfsr_step(lfsr);
        end
        return b;
    endfunction

    // Ethernet CRC, one data bit at a time, lsb first
    function automatic logic [31:0] fcs_step(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ b[i]) begin
                c = (c >> 1) ^ `BASER_CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    function automatic logic [7:0] term_type(input int lanes);
        case (lanes)
            0: return `BASER_BT_TERM_0;
            1: return `BASER_BT_TERM_1;
            2: return `BASER_BT_TERM_2;
            3: return `BASER_BT_TERM_3;
            4: return `BASER_BT_TERM_4;
            5: return `BASER_BT_TERM_5;
            6: return `BASER_BT_TERM_6;
            default: return `BASER_BT_TERM_7;
        endcase
    endfunction

    // lead idle, start, end block and three trailing idles, plus data and bad blocks
    function automatic int row_blocks(input row_t r);
        int n;
        n = r.pay_len + 4;
        return 6 + (r.bad_block ? 2 : 0) + (r.abort ? n / 16 : n / 8);
    endfunction

    function automatic void compare_field(input string name, input logic [31:0] got,
                                          input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endfunction

    function automatic void check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("error at %0t: %s", $time, what);
            errors++;
        end
    endfunction

    task automatic send_block(input logic [1:0] hdr, input logic [63:0] blk);
        @(negedge clk);
        rx_hdr = hdr;
        rx_hdr_valid = 1'b1;
        rx_data = blk[31:0];
        @(negedge clk);
        rx_hdr_valid = 1'b0;
        rx_data = blk[63:32];
    endtask

    task automatic queue_beats(input logic [7:0] bytes [$], input logic tuser);
        rx_beat_t beat;
        int       n;
        n = bytes.size();
        for (int i = 0; i < n; i += 4) begin
            beat = '0;
            for (int j = 0; j < 4; j++) begin
                if (i + j < n) begin
                    beat.tdata[8*j +: 8] = bytes[i+j];
                    beat.tkeep[j] = 1'b1;
                end
            end
            beat.tlast = i + 4 >= n;
            beat.tuser = beat.tlast && tuser;
            exp_beats.push_back(beat);
        end
    endtask

    task automatic check_beat();
        rx_beat_t    exp;
        logic [31:0] mask;
        if (exp_beats.size() == 0) begin
            check_true(1'b0, "beat arrived while no beat was expected");
        end else begin
            exp = exp_beats.pop_front();
            for (int j = 0; j < 4; j++) begin
                mask[8*j +: 8] = {8{exp.tkeep[j]}};
            end
            compare_field("rx_beat.tdata", rx_beat.tdata & mask, exp.tdata);
            compare_field("rx_beat.tkeep", rx_beat.tkeep, exp.tkeep);
            compare_field("rx_beat.tlast", rx_beat.tlast, exp.tlast);
            compare_field("rx_beat.tuser", rx_beat.tuser, exp.tuser);
        end
        check_true(in_frame, "beat arrived before its start of packet");
        if (first_beat) begin
            check_true(cycle == start_cycle + 1, "first beat not one cycle after the start");
        end
        first_beat = 1'b0;
        if (rx_beat.tlast) begin
            in_frame = 1'b0;
        end
    endtask

    task automatic check_status();
        rx_stat_t exp;
        check_true(rx_valid && rx_beat.tlast, "end-of-frame status without a tlast beat");
        if (exp_stats.size() == 0) begin
            check_true(1'b0, "end-of-frame status while none was expected");
        end else begin
            exp = exp_stats.pop_front();
            compare_field("rx_stat.pkt_good", rx_stat.pkt_good, exp.pkt_good);
            compare_field("rx_stat.pkt_bad", rx_stat.pkt_bad, exp.pkt_bad);
            compare_field("rx_stat.err_bad_fcs", rx_stat.err_bad_fcs, exp.err_bad_fcs);
            compare_field("rx_stat.err_framing", rx_stat.err_framing, exp.err_framing);
            compare_field("rx_stat.pkt_len", rx_stat.pkt_len, exp.pkt_len);
        end
    endtask

    // outputs settle after the rising edge, so they are read on the falling one
    always @(negedge clk) begin
        if (!reset_crc) begin
            if (rx_start_packet) begin
                starts_seen++;
                check_true(!in_frame, "start of packet while a frame is open");
                in_frame = 1'b1;
                first_beat = 1'b1;
                start_cycle = cycle;
            end
            if (rx_valid) begin
                check_beat();
            end
            if (rx_stat.pkt_good || rx_stat.pkt_bad) begin
                check_status();
            end else begin
                check_true(!rx_stat.err_bad_fcs && !rx_stat.err_framing,
                           "error status raised outside the end of a frame");
            end
            if (stat_rx_err_bad_block) begin
                bad_seen++;
            end
        end
    end

    task automatic run_row(input int idx);
        row_t        r;
        logic [7:0]  frame [$];
        logic [7:0]  sent [$];
        logic [31:0] crc;
        logic [63:0] blk;
        rx_stat_t    st;
        int          n;
        int          blocks;
        int          pos;
        int          err_before;
        int          starts_before;
        int          bad_before;
        r = rows[idx];
        err_before = errors;
        starts_before = starts_seen;
        bad_before = bad_seen;
        cfg_rx_enable = r.enable;

        crc = '1;
        for (int i = 0; i < r.pay_len; i++) begin
            frame.push_back(random_byte());
            crc = fcs_step(crc, frame[i]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            frame.push_back(crc[8*i +: 8]);
        end
        if (r.corrupt_fcs) begin
            frame[r.pay_len] = ~frame[r.pay_len];
        end
        n = frame.size();
        // an aborted frame is cut halfway through its data blocks
        blocks = r.abort ? n / 16 : n / 8;

        if (r.outcome != OUT_NONE) begin
            for (int i = 0; i < (r.abort ? 8 * blocks : n); i++) begin
                sent.push_back(frame[i]);
            end
            if (r.abort) begin
                for (int i = 0; i < 4; i++) begin
                    sent.push_back(IDLE_BLOCK[8*i +: 8]);
                end
            end
            queue_beats(sent, r.outcome != OUT_GOOD);
            st = '0;
            st.pkt_good = r.outcome == OUT_GOOD;
            st.pkt_bad = r.outcome != OUT_GOOD;
            st.err_bad_fcs = r.outcome == OUT_BAD_FCS;
            st.err_framing = r.outcome == OUT_FRAMING;
            st.pkt_len = sent.size();
            exp_stats.push_back(st);
        end

        send_block(`BASER_SYNC_CTRL, IDLE_BLOCK);
        if (r.bad_block) begin
            send_block(2'b11, IDLE_BLOCK);
            // type 0x00 is no valid block type
            send_block(`BASER_SYNC_CTRL, 64'd0);
        end
        send_block(`BASER_SYNC_CTRL, START_BLOCK);
        pos = 0;
        for (int b = 0; b < blocks; b++) begin
            for (int j = 0; j < 8; j++) begin
                blk[8*j +: 8] = frame[pos+j];
            end
            pos += 8;
            send_block(`BASER_SYNC_DATA, blk);
        end
        if (r.abort) begin
            send_block(`BASER_SYNC_CTRL, IDLE_BLOCK);
        end else begin
            blk = '0;
            blk[7:0] = term_type(r.term_lane);
            for (int j = 0; j < r.term_lane; j++) begin
                blk[8*(j+1) +: 8] = frame[pos+j];
            end
            send_block(`BASER_SYNC_CTRL, blk);
        end
        repeat (3) send_block(`BASER_SYNC_CTRL, IDLE_BLOCK);
        while (exp_beats.size() != 0 || exp_stats.size() != 0) begin
            @(negedge clk);
        end

        check_true(starts_seen - starts_before == (r.outcome == OUT_NONE ? 0 : 1),
                   "wrong number of start-of-packet pulses");
        check_true(bad_seen - bad_before == (r.bad_block ? 2 : 0),
                   "wrong number of bad-block strobes");
        check_true(!in_frame, "frame still open after its end");
        if (errors == err_before) begin
            $display("row %0d: payload %0d, lane %0d, %s: ok",
                     idx, r.pay_len, r.term_lane, r.outcome.name());
        end else begin
            $display("row %0d: payload %0d, lane %0d, %s: %0d errors",
                     idx, r.pay_len, r.term_lane, r.outcome.name(), errors - err_before);
        end
    endtask

    initial begin
        reset_crc = 1'b1;
        rx_data = '0;
        rx_hdr = `BASER_SYNC_CTRL;
        rx_hdr_valid = 1'b0;
        cfg_rx_enable = 1'b1;
        lfsr = 16'd62855;
        cycle = 0;
        cycle_limit = 0;
        errors = 0;
        checks = 0;
        starts_seen = 0;
        bad_seen = 0;
        start_cycle = 0;
        in_frame = 1'b0;
        first_beat = 1'b0;

        // payload, lane, corrupt FCS, abort, bad block, enable, outcome
        rows[0] = '{16'd64, 3'd4, 1'b0, 1'b0, 1'b0, 1'b1, OUT_GOOD};
        rows[1] = '{16'd65, 3'd5, 1'b0, 1'b0, 1'b0, 1'b1, OUT_GOOD};
        rows[2] = '{16'd66, 3'd6, 1'b0, 1'b0, 1'b0, 1'b1, OUT_GOOD};
        rows[3] = '{16'd67, 3'd7, 1'b0, 1'b0, 1'b0, 1'b1, OUT_GOOD};
        rows[4] = '{16'd60, 3'd0, 1'b0, 1'b0, 1'b0, 1'b1, OUT_GOOD};
        rows[5] = '{16'd61, 3'd1, 1'b0, 1'b0, 1'b0, 1'b1, OUT_GOOD};
        rows[6] = '{16'd62, 3'd2, 1'b0, 1'b0, 1'b0, 1'b1, OUT_GOOD};
        rows[7] = '{16'd63, 3'd3, 1'b0, 1'b0, 1'b0, 1'b1, OUT_GOOD};
        rows[8] = '{16'd63, 3'd3, 1'b1, 1'b0, 1'b0, 1'b1, OUT_BAD_FCS};
        rows[9] = '{16'd70, 3'd2, 1'b0, 1'b1, 1'b0, 1'b1, OUT_FRAMING};
        rows[10] = '{16'd61, 3'd1, 1'b0, 1'b0, 1'b1, 1'b1, OUT_GOOD};
        rows[11] = '{16'd64, 3'd4, 1'b0, 1'b0, 1'b0, 1'b0, OUT_NONE};
        rows[12] = '{16'd65, 3'd5, 1'b0, 1'b0, 1'b0, 1'b1, OUT_GOOD};

        // twice the words of all rows plus a margin, two words per block
        cycle_limit = 100;
        for (int i = 0; i < NUM_ROWS; i++) begin
            cycle_limit += 4 * row_blocks(rows[i]);
        end

        repeat (5) @(negedge clk);
        reset_crc = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
